//--- ex_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module ex_stage (
    input  wire                 rv_pkg::id_ex_t i_id_ex,
    input  wire  [`RV_XLEN-1:0] i_mem_fwd,
    input  wire  [`RV_XLEN-1:0] i_wb_fwd,
    hazard_if.pipe              hz,
    output logic [`RV_XLEN-1:0] o_target,
    output rv_pkg::ex_mem_t     o_ex_mem
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] c;

    always_comb begin
        case (hz.fwd_a)
            FWD_MEM: op_a = i_mem_fwd;
            FWD_WB:  op_a = i_wb_fwd;
            default: op_a = i_id_ex.data1;
        endcase
        case (hz.fwd_b)
            FWD_MEM: op_b = i_mem_fwd;
            FWD_WB:  op_b = i_wb_fwd;
            default: op_b = i_id_ex.data2;
        endcase
    end

    assign alu_b = (i_id_ex.ir_type == IR_ALU_R) ? op_b : i_id_ex.imm;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_SUB: c = op_a - alu_b;
            ALU_AND: c = op_a & alu_b;
            ALU_OR:  c = op_a | alu_b;
            ALU_XOR: c = op_a ^ alu_b;
            ALU_SLT: c = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_SLL: c = op_a << alu_b[4:0];
            ALU_SRL: c = op_a >> alu_b[4:0];
            default: c = op_a + alu_b;
        endcase
        if (i_id_ex.ir_type == IR_LUI) begin
            c = i_id_ex.imm;
        end
    end

    // funct3[0] turns BEQ into BNE
    assign hz.jump = (i_id_ex.ir_type == IR_JAL) ||
                     (i_id_ex.ir_type == IR_BRANCH &&
                      ((op_a == op_b) != i_id_ex.funct3[0]));
    assign o_target = i_id_ex.pc + i_id_ex.imm;

    assign o_ex_mem = '{pc4: i_id_ex.pc + `RV_XLEN'(4), c: c, b: op_b, rd: i_id_ex.rd,
                        ir_type: i_id_ex.ir_type, wr_reg: i_id_ex.wr_reg};

endmodule

`default_nettype wire

//--- hazard_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;
    import rv_pkg::*;

    // Register addresses seen by the unit
    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    logic [4:0] ex_rs1;
    logic [4:0] ex_rs2;
    logic [4:0] ex_rd;
    logic [4:0] mem_rd;
    logic [4:0] wb_rd;
    logic       ex_wr_reg;
    logic       ex_is_load;
    logic       mem_wr_reg;
    logic       mem_req;
    logic       wb_wr_reg;
    logic       jump;

    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    logic       stall;
    logic       flush;
    logic       freeze;

    modport unit (
        input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_wr_reg, ex_is_load,
        input  mem_rd, mem_wr_reg, mem_req, wb_rd, wb_wr_reg, jump,
        output fwd_a, fwd_b, stall, flush, freeze
    );

    modport pipe (
        input  fwd_a, fwd_b, stall, flush, freeze,
        output jump
    );

endinterface

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module id_stage (
    input  wire             clk,
    input  wire             i_rst,
    input  wire             rv_pkg::if_id_t  i_if_id,
    input  wire             rv_pkg::mem_wb_t i_wb,
    output logic [4:0]      o_rs1,
    output logic [4:0]      o_rs2,
    output rv_pkg::id_ex_t  o_id_ex
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] ir;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    ir_type_e            ir_type;
    alu_op_e             alu_op;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] data1;
    logic [`RV_XLEN-1:0] data2;
    logic                wr_reg;

    assign ir     = i_if_id.ir;
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    always_comb begin
        case (opcode)
            `RV_OP_OP:     ir_type = IR_ALU_R;
            `RV_OP_IMM:    ir_type = IR_ALU_I;
            `RV_OP_LUI:    ir_type = IR_LUI;
            `RV_OP_LOAD:   ir_type = IR_LOAD;
            `RV_OP_STORE:  ir_type = IR_STORE;
            `RV_OP_BRANCH: ir_type = IR_BRANCH;
            `RV_OP_JAL:    ir_type = IR_JAL;
            default:       ir_type = IR_NONE;
        endcase
    end

    // Loads, stores and unsupported funct3 fall back to add
    always_comb begin
        alu_op = ALU_ADD;
        if (ir_type == IR_ALU_R || ir_type == IR_ALU_I) begin
            case (funct3)
                3'b000:  alu_op = (ir_type == IR_ALU_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (ir_type)
            IR_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IR_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            IR_LUI:    imm = {ir[31:12], 12'b0};
            IR_JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:   imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    // Unused source fields read as x0 so they never forward or stall
    assign o_rs1 = (ir_type inside {IR_NONE, IR_LUI, IR_JAL}) ? 5'd0 : ir[19:15];
    assign o_rs2 = (ir_type inside {IR_ALU_R, IR_STORE, IR_BRANCH}) ? ir[24:20] : 5'd0;
    assign wr_reg = ir_type inside {IR_ALU_R, IR_ALU_I, IR_LUI, IR_LOAD, IR_JAL};

    rf32x32 rf32x32_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_wr(i_wb.wr_reg),
        .i_wr_addr(i_wb.rd),
        .i_wr_data(i_wb.wdata),
        .i_rd1_addr(o_rs1),
        .i_rd2_addr(o_rs2),
        .o_rd1_data(data1),
        .o_rd2_data(data2)
    );

    assign o_id_ex = '{pc: i_if_id.pc, rs1: o_rs1, rs2: o_rs2, rd: ir[11:7],
                       data1: data1, data2: data2, imm: imm, ir_type: ir_type,
                       alu_op: alu_op, funct3: funct3, wr_reg: wr_reg};

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module mem_stage (
    input  wire                 rv_pkg::ex_mem_t i_ex_mem,
    input  wire  [`RV_XLEN-1:0] i_drdata,
    output logic                o_mreq,
    output logic                o_write,
    output logic [`RV_XLEN-1:0] o_dad,
    output logic [`RV_XLEN-1:0] o_dwdata,
    output rv_pkg::mem_wb_t     o_mem_wb
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] wdata;

    assign o_mreq   = (i_ex_mem.ir_type == IR_LOAD) || (i_ex_mem.ir_type == IR_STORE);
    assign o_write  = (i_ex_mem.ir_type == IR_STORE);
    assign o_dad    = i_ex_mem.c;
    assign o_dwdata = i_ex_mem.b;

    // Writeback source
    always_comb begin
        case (i_ex_mem.ir_type)
            IR_LOAD: wdata = i_drdata;
            IR_JAL:  wdata = i_ex_mem.pc4;
            default: wdata = i_ex_mem.c;
        endcase
    end

    assign o_mem_wb = '{wdata: wdata, rd: i_ex_mem.rd, wr_reg: i_ex_mem.wr_reg};

endmodule

`default_nettype wire

//--- pipe_hazard_u.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_hazard_u (
    input  wire    i_acki_n,
    input  wire    i_ackd_n,
    hazard_if.unit hz
);
    import rv_pkg::*;

    logic load_use;

    // MEM is younger than WB, so it is checked last and wins
    function automatic fwd_sel_e fwd_for(
        input logic [4:0] rs,
        input logic       mem_wr,
        input logic [4:0] mem_rd,
        input logic       wb_wr,
        input logic [4:0] wb_rd
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (rs != 5'd0 && wb_wr && wb_rd == rs) begin
            sel = FWD_WB;
        end
        if (rs != 5'd0 && mem_wr && mem_rd == rs) begin
            sel = FWD_MEM;
        end
        return sel;
    endfunction

    assign hz.fwd_a = fwd_for(hz.ex_rs1, hz.mem_wr_reg, hz.mem_rd, hz.wb_wr_reg, hz.wb_rd);
    assign hz.fwd_b = fwd_for(hz.ex_rs2, hz.mem_wr_reg, hz.mem_rd, hz.wb_wr_reg, hz.wb_rd);

    // Load in EX feeding the instruction in ID
    assign load_use = hz.ex_is_load && hz.ex_wr_reg && (hz.ex_rd != 5'd0) &&
                      (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2);

    assign hz.stall  = load_use;
    assign hz.flush  = hz.jump;
    assign hz.freeze = i_acki_n || (hz.mem_req && i_ackd_n);

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  i_rst,
    input  wire  i_hold,
    input  wire  i_flush,
    input  wire  T i_d,
    output T     o_q
);

    // Hold wins over flush so a frozen pipe keeps its contents
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_q <= T'('0);
        end else if (!i_hold) begin
            if (i_flush) begin
                o_q <= T'('0);
            end else begin
                o_q <= i_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- rf32x32.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rf32x32 (
    input  wire                 clk,
    input  wire                 i_rst,
    input  wire                 i_wr,
    input  wire  [4:0]          i_wr_addr,
    input  wire  [`RV_XLEN-1:0] i_wr_data,
    input  wire  [4:0]          i_rd1_addr,
    input  wire  [4:0]          i_rd2_addr,
    output logic [`RV_XLEN-1:0] o_rd1_data,
    output logic [`RV_XLEN-1:0] o_rd2_data
);

    logic [`RV_XLEN-1:0] regs [1:31];
    logic                wr_en;

    // x0 is never stored
    assign wr_en = i_wr && !i_rst && (i_wr_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-through so WB data reaches ID in the same cycle
    assign o_rd1_data = (i_rd1_addr == 5'd0) ? '0 :
                        (wr_en && i_rd1_addr == i_wr_addr) ? i_wr_data : regs[i_rd1_addr];
    assign o_rd2_data = (i_rd2_addr == 5'd0) ? '0 :
                        (wr_en && i_rd2_addr == i_wr_addr) ? i_wr_data : regs[i_rd2_addr];

endmodule

`default_nettype wire

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

`define RV_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

// Base opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

`endif

//--- rv_pkg.sv
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

    // Bubble must encode as zero
    typedef enum logic [3:0] {
        IR_NONE,
        IR_ALU_R,
        IR_ALU_I,
        IR_LUI,
        IR_LOAD,
        IR_STORE,
        IR_BRANCH,
        IR_JAL
    } ir_type_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // Operand source for EX
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] ir;
    } if_id_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data1;
        logic [`RV_XLEN-1:0] data2;
        logic [`RV_XLEN-1:0] imm;
        ir_type_e            ir_type;
        alu_op_e             alu_op;
        logic [2:0]          funct3;
        logic                wr_reg;
    } id_ex_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc4;
        logic [`RV_XLEN-1:0] c;
        logic [`RV_XLEN-1:0] b;
        logic [4:0]          rd;
        ir_type_e            ir_type;
        logic                wr_reg;
    } ex_mem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] wdata;
        logic [4:0]          rd;
        logic                wr_reg;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_top;

    logic        clk = 1'b0;
    logic        i_rst;
    logic        i_acki_n;
    logic        i_ackd_n;
    logic [31:0] i_idt;
    logic [31:0] i_drdata;
    logic [31:0] o_iad;
    logic [31:0] o_dad;
    logic [31:0] o_dwdata;
    logic        o_mreq;
    logic        o_write;

    logic [31:0] rom  [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] gold [0:31];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    integer      seed = 39991;
    int unsigned iwait;
    int unsigned dwait;
    int          prog_len = 0;
    int          n_exp = 0;
    int          seen = 0;
    int          value_errs = 0;
    int          count_errs = 0;
    int          timeouts = 0;
    logic        built = 1'b0;

    always #50 clk = ~clk;

    top DUT (
        .clk(clk),
        .i_rst(i_rst),
        .o_iad(o_iad),
        .i_idt(i_idt),
        .i_acki_n(i_acki_n),
        .o_dad(o_dad),
        .o_dwdata(o_dwdata),
        .i_drdata(i_drdata),
        .o_mreq(o_mreq),
        .o_write(o_write),
        .i_ackd_n(i_ackd_n)
    );

    // Both memories read combinationally
    assign i_idt    = (^o_iad === 1'bx) ? `RV_NOP : rom[o_iad[9:2]];
    assign i_drdata = (^o_dad === 1'bx) ? 32'd0 : dmem[o_dad[9:2]];

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {~idx, idx, 8'h5A, idx ^ 8'h3C};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic put(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic store_checked(input logic [4:0] rs, input logic [11:0] addr);
        put(stype(addr, rs, 5'd0));
        exp_addr.push_back({20'd0, addr});
        exp_data.push_back(gold[rs]);
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            rom[i]  = `RV_NOP;
            dmem[i] = fill_word(i[7:0]);
        end
        gold[0] = 32'd0;
        // Dependent ALU chain
        put({20'h12345, 5'd1, `RV_OP_LUI});
        gold[1] = 32'h1234_5000;
        put(itype(12'h678, 5'd1, 3'b000, 5'd1, `RV_OP_IMM));
        gold[1] = gold[1] + 32'h678;
        put(itype(12'd100, 5'd0, 3'b000, 5'd2, `RV_OP_IMM));
        gold[2] = 32'd100;
        put(itype(12'hFF9, 5'd2, 3'b000, 5'd3, `RV_OP_IMM));
        gold[3] = gold[2] - 32'd7;
        put(rtype(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
        gold[4] = gold[3] + gold[2];
        put(rtype(7'h20, 5'd1, 5'd4, 3'b000, 5'd5));
        gold[5] = gold[4] - gold[1];
        put(rtype(7'h00, 5'd1, 5'd5, 3'b111, 5'd6));
        gold[6] = gold[5] & gold[1];
        put(rtype(7'h00, 5'd3, 5'd6, 3'b110, 5'd7));
        gold[7] = gold[6] | gold[3];
        put(rtype(7'h00, 5'd1, 5'd7, 3'b100, 5'd8));
        gold[8] = gold[7] ^ gold[1];
        put(rtype(7'h00, 5'd2, 5'd5, 3'b010, 5'd9));
        gold[9] = ($signed(gold[5]) < $signed(gold[2])) ? 32'd1 : 32'd0;
        put(rtype(7'h00, 5'd9, 5'd3, 3'b001, 5'd10));
        gold[10] = gold[3] << gold[9][4:0];
        put(rtype(7'h00, 5'd9, 5'd1, 3'b101, 5'd11));
        gold[11] = gold[1] >> gold[9][4:0];
        put(itype(12'h0FF, 5'd1, 3'b111, 5'd12, `RV_OP_IMM));
        gold[12] = gold[1] & 32'h0FF;
        put(itype(12'h700, 5'd12, 3'b110, 5'd13, `RV_OP_IMM));
        gold[13] = gold[12] | 32'h700;
        put(itype(12'hFFF, 5'd13, 3'b100, 5'd14, `RV_OP_IMM));
        gold[14] = gold[13] ^ 32'hFFFF_FFFF;
        put(itype(12'd5, 5'd14, 3'b010, 5'd15, `RV_OP_IMM));
        gold[15] = ($signed(gold[14]) < 32'sd5) ? 32'd1 : 32'd0;
        // Newest result first so store data is forwarded
        for (int k = 15; k >= 1; k--) begin
            store_checked(k[4:0], 12'h100 + 12'(4 * k));
        end
        // Load then dependent add
        put(itype(12'h200, 5'd0, 3'b010, 5'd16, `RV_OP_LOAD));
        gold[16] = fill_word(8'h80);
        put(rtype(7'h00, 5'd2, 5'd16, 3'b000, 5'd17));
        gold[17] = gold[16] + gold[2];
        store_checked(5'd17, 12'h180);
        // Taken BEQ and BNE that each skip two stores
        put(btype(13'd12, 5'd2, 5'd2, 3'b000));
        put(stype(12'h1E0, 5'd2, 5'd0));
        put(stype(12'h1E4, 5'd2, 5'd0));
        put(btype(13'd12, 5'd3, 5'd2, 3'b001));
        put(stype(12'h1E8, 5'd2, 5'd0));
        put(stype(12'h1EC, 5'd2, 5'd0));
        // Not taken
        put(btype(13'd8, 5'd3, 5'd2, 3'b000));
        store_checked(5'd3, 12'h1C8);
        gold[18] = 32'(prog_len) * 32'd4 + 32'd4;
        put(jtype(21'd12, 5'd18));
        put(stype(12'h1F0, 5'd2, 5'd0));
        put(stype(12'h1F4, 5'd2, 5'd0));
        store_checked(5'd18, 12'h1CC);
        // x0 stays zero
        put(itype(12'd55, 5'd0, 3'b000, 5'd0, `RV_OP_IMM));
        store_checked(5'd0, 12'h1D0);
        put(jtype(21'd0, 5'd0));
        n_exp = exp_addr.size();
    endtask

    task automatic check_idle(input int cyc);
        assert (o_mreq === 1'b0 && o_write === 1'b0 && o_iad === `RV_RESET_PC) else begin
            value_errs++;
            $display("FAILED at %0t: bus not idle at reset edge %0d (mreq=%b write=%b iad=%h)",
                     $time, cyc, o_mreq, o_write, o_iad);
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d wrong values, %0d stream errors, %0d timeouts",
                 value_errs, count_errs, timeouts);
        if (value_errs + count_errs + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // Random acknowledge delays where the data ack also releases the fetch side
    always @(posedge clk) begin
        if (i_rst) begin
            i_acki_n <= 1'b1;
            i_ackd_n <= 1'b1;
            iwait = 0;
            dwait = 0;
        end else begin
            if (o_mreq && o_write && !i_ackd_n) begin
                dmem[o_dad[9:2]] <= o_dwdata;
            end
            if (!i_acki_n) begin
                iwait = $unsigned($random(seed)) % 4;
            end else if (iwait != 0) begin
                iwait = iwait - 1;
            end
            if (!i_ackd_n) begin
                dwait = $unsigned($random(seed)) % 4;
            end else if (o_mreq && dwait != 0) begin
                dwait = dwait - 1;
            end
            i_ackd_n <= (dwait != 0);
            i_acki_n <= (iwait != 0) && (dwait != 0);
        end
    end

    // Store monitor
    always @(negedge clk) begin
        if (!i_rst && o_mreq && o_write && !i_ackd_n) begin
            if (seen < n_exp) begin
                assert (o_dad === exp_addr[seen] && o_dwdata === exp_data[seen]) else begin
                    value_errs++;
                    $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, seen, o_dwdata, o_dad, exp_data[seen], exp_addr[seen]);
                end
            end else begin
                count_errs++;
                $display("Extra store of %h to address %h at time %0t", o_dwdata, o_dad, $time);
            end
            seen++;
        end
    end

    initial begin
        i_rst    = 1'b1;
        i_acki_n = 1'b1;
        i_ackd_n = 1'b1;
        build_program();
        built = 1'b1;
        for (int cyc = 1; cyc <= 8; cyc++) begin
            @(posedge clk);
            if (cyc == 8) begin
                i_rst <= 1'b0;
            end
            @(negedge clk);
            check_idle(cyc);
        end
        wait (seen >= n_exp);
        // Program now spins so any further store is an extra one
        repeat (20) @(posedge clk);
        report_and_finish();
    end

    // Watchdog
    initial begin
        wait (built);
        repeat (prog_len * 4 * 6 + 8) @(posedge clk);
        timeouts++;
        $display("Timeout: only %0d of %0d expected stores seen after %0d cycles",
                 seen, n_exp, prog_len * 4 * 6 + 8);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module top (
    input  wire                 clk,
    input  wire                 i_rst,

    // Instruction memory
    output logic [`RV_XLEN-1:0] o_iad,
    input  wire  [`RV_XLEN-1:0] i_idt,
    input  wire                 i_acki_n,

    // Data memory
    output logic [`RV_XLEN-1:0] o_dad,
    output logic [`RV_XLEN-1:0] o_dwdata,
    input  wire  [`RV_XLEN-1:0] i_drdata,
    output logic                o_mreq,
    output logic                o_write,
    input  wire                 i_ackd_n
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] target;
    if_id_t              if_id_d;
    if_id_t              if_id_q;
    id_ex_t              id_ex_d;
    id_ex_t              id_ex_q;
    ex_mem_t             ex_mem_d;
    ex_mem_t             ex_mem_q;
    mem_wb_t             mem_wb_d;
    mem_wb_t             mem_wb_q;

    hazard_if hz();

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= `RV_RESET_PC;
        end else if (!hz.freeze) begin
            if (hz.jump) begin
                pc <= target;
            end else if (!hz.stall) begin
                pc <= pc + `RV_XLEN'(4);
            end
        end
    end

    assign o_iad = pc;

    // Squashed fetch enters IF/ID as a NOP word
    assign if_id_d = '{pc: pc, ir: hz.flush ? `RV_NOP : i_idt};

    assign hz.ex_rs1     = id_ex_q.rs1;
    assign hz.ex_rs2     = id_ex_q.rs2;
    assign hz.ex_rd      = id_ex_q.rd;
    assign hz.ex_wr_reg  = id_ex_q.wr_reg;
    assign hz.ex_is_load = (id_ex_q.ir_type == IR_LOAD);
    assign hz.mem_rd     = ex_mem_q.rd;
    assign hz.mem_wr_reg = ex_mem_q.wr_reg;
    assign hz.mem_req    = o_mreq;
    assign hz.wb_rd      = mem_wb_q.rd;
    assign hz.wb_wr_reg  = mem_wb_q.wr_reg;

    pipe_reg #(.T(if_id_t)) if_id_reg_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_hold(hz.freeze | hz.stall),
        .i_flush(1'b0),
        .i_d(if_id_d),
        .o_q(if_id_q)
    );

    id_stage id_stage_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_if_id(if_id_q),
        .i_wb(mem_wb_q),
        .o_rs1(hz.id_rs1),
        .o_rs2(hz.id_rs2),
        .o_id_ex(id_ex_d)
    );

    // Load-use bubble goes in here
    pipe_reg #(.T(id_ex_t)) id_ex_reg_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_hold(hz.freeze),
        .i_flush(hz.flush | hz.stall),
        .i_d(id_ex_d),
        .o_q(id_ex_q)
    );

    ex_stage ex_stage_inst (
        .i_id_ex(id_ex_q),
        .i_mem_fwd(mem_wb_d.wdata),
        .i_wb_fwd(mem_wb_q.wdata),
        .hz(hz.pipe),
        .o_target(target),
        .o_ex_mem(ex_mem_d)
    );

    pipe_reg #(.T(ex_mem_t)) ex_mem_reg_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_hold(hz.freeze),
        .i_flush(1'b0),
        .i_d(ex_mem_d),
        .o_q(ex_mem_q)
    );

    mem_stage mem_stage_inst (
        .i_ex_mem(ex_mem_q),
        .i_drdata(i_drdata),
        .o_mreq(o_mreq),
        .o_write(o_write),
        .o_dad(o_dad),
        .o_dwdata(o_dwdata),
        .o_mem_wb(mem_wb_d)
    );

    pipe_reg #(.T(mem_wb_t)) mem_wb_reg_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_hold(hz.freeze),
        .i_flush(1'b0),
        .i_d(mem_wb_d),
        .o_q(mem_wb_q)
    );

    pipe_hazard_u pipe_hazard_u_inst (
        .i_acki_n(i_acki_n),
        .i_ackd_n(i_ackd_n),
        .hz(hz.unit)
    );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
rv_pkg.sv
hazard_if.sv
pipe_reg.sv
rf32x32.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
pipe_hazard_u.sv
top.sv
tb_top.sv
